//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////////////////
    // fetch side widths
    ////////////////////////////////////////////////////////////////////////

    // byte address, one word per instruction
    parameter int addr_width = 32;

    typedef logic [31:0] word_t;

    // addi x0, x0, 0
    parameter word_t nop_instr = 32'h0000_0013;

    ////////////////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////////////////

    // size code: 0 byte, 1 half, 2 word
    parameter logic [1:0] mem_size_word = 2'd2;

    ////////////////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        miss_wait,
        refill_done
    } st_e;

endpackage

`default_nettype wire

//--- icache_req_buf.sv
`default_nettype none

module icache_req_buf (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              we,
    input  logic [icache_pkg::addr_width-1:0] addr,
    input  logic                              inv,
    output logic [icache_pkg::addr_width-1:0] buf_addr,
    output logic                              buf_inv
);

    // op flag decides the path after lookup, so it comes out of reset clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_inv <= 1'b0;
        end else if (we) begin
            buf_inv <= inv;
        end
    end

    // address is payload only
    always_ff @(posedge clk) begin
        if (we) begin
            buf_addr <= addr;
        end
    end

endmodule

`default_nettype wire

//--- icache_way_ram.sv
`default_nettype none

module icache_way_ram #(
    parameter type entry_t     = logic,
    parameter int  depth_width = 4
) (
    input  logic                   clk,
    input  logic [depth_width-1:0] raddr,
    output entry_t                 rdata,
    input  logic [depth_width-1:0] waddr,
    input  entry_t                 wdata,
    input  logic                   we
);

    localparam int depth = 1 << depth_width;

    ////////////////////////////////////////////////////////////////////////
    // storage for one way
    ////////////////////////////////////////////////////////////////////////

    entry_t mem_q [depth];

    // write port, refill only
    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[waddr] <= wdata;
        end
    end

    // registered read, data shows up the cycle after the address
    // same-address read during write returns the old entry
    always_ff @(posedge clk) begin
        rdata <= mem_q[raddr];
    end

endmodule

`default_nettype wire

//--- icache_lru.sv
`default_nettype none

module icache_lru #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [index_width-1:0] index,
    input  logic                   use_way0,
    input  logic                   use_way1,
    output logic                   victim
);

    localparam int sets = 1 << index_width;

    // one bit per set, names the way used least recently
    logic lru_q [sets];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < sets; s++) begin
                lru_q[s] <= 1'b0;
            end
        end else if (use_way0) begin
            lru_q[index] <= 1'b1;
        end else if (use_way1) begin
            lru_q[index] <= 1'b0;
        end
    end

    // refill goes to the lru way of the buffered set
    assign victim = lru_q[index];

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`default_nettype none

module icache_ctrl #(
    parameter int  index_width  = 4,
    parameter int  offset_width = 2,
    localparam int tag_width    = icache_pkg::addr_width - index_width - offset_width - 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              fetch_valid,
    output logic                              fetch_ready,
    output logic                              buf_we,
    input  logic [icache_pkg::addr_width-1:0] buf_addr,
    input  logic                              buf_inv,
    input  logic [tag_width-1:0]              tag0,
    input  logic [tag_width-1:0]              tag1,
    input  logic                              victim,
    output logic                              use_way0,
    output logic                              use_way1,
    output logic [1:0]                        tag_we,
    output logic [1:0]                        line_we,
    output logic                              mem_req,
    output logic [icache_pkg::addr_width-1:0] mem_addr,
    output logic [1:0]                        mem_size,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    input  logic                              stall,
    output logic                              resp_valid,
    output logic                              sel_way,
    output logic                              sel_return,
    output logic [offset_width-1:0]           sel_word
);

    localparam int sets    = 1 << index_width;
    localparam int low_bit = offset_width + 2;

    icache_pkg::st_e state_q, state_d;

    logic [1:0]             valid_q [sets];
    logic [index_width-1:0] buf_index;
    logic [tag_width-1:0]   buf_tag;
    logic [1:0]             hit_vec;
    logic                   inv_all;
    logic                   fill;

    assign buf_index = buf_addr[low_bit+index_width-1:low_bit];
    assign buf_tag   = buf_addr[icache_pkg::addr_width-1:low_bit+index_width];
    assign sel_word  = buf_addr[low_bit-1:2];

    // tags were read at acceptance, compared against the buffered tag
    assign hit_vec[0] = valid_q[buf_index][0] && (tag0 == buf_tag);
    assign hit_vec[1] = valid_q[buf_index][1] && (tag1 == buf_tag);

    ////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d    = state_q;
        fetch_ready = 1'b0;
        resp_valid = 1'b0;
        mem_req    = 1'b0;
        sel_return = 1'b0;
        inv_all    = 1'b0;
        fill       = 1'b0;
        case (state_q)
            icache_pkg::idle: begin
                fetch_ready = 1'b1;
                if (fetch_valid) begin
                    state_d = icache_pkg::lookup;
                end
            end
            icache_pkg::lookup: begin
                if (buf_inv) begin
                    inv_all = 1'b1;
                    state_d = icache_pkg::idle;
                end else if (|hit_vec) begin
                    // hit, next fetch may be taken in the same cycle
                    resp_valid  = 1'b1;
                    fetch_ready = !stall;
                    if (!stall) begin
                        state_d = fetch_valid ? icache_pkg::lookup : icache_pkg::idle;
                    end
                end else begin
                    state_d = icache_pkg::miss_req;
                end
            end
            icache_pkg::miss_req: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    state_d = icache_pkg::miss_wait;
                end
            end
            icache_pkg::miss_wait: begin
                // selector samples the returning line on the data_ok edge
                sel_return = 1'b1;
                if (mem_data_ok) begin
                    fill    = 1'b1;
                    state_d = icache_pkg::refill_done;
                end
            end
            icache_pkg::refill_done: begin
                resp_valid  = 1'b1;
                sel_return  = 1'b1;
                fetch_ready = !stall;
                if (!stall) begin
                    state_d = fetch_valid ? icache_pkg::lookup : icache_pkg::idle;
                end
            end
            default: begin
                state_d = icache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= icache_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign buf_we = fetch_valid && fetch_ready;

    ////////////////////////////////////////////////////////////////////////
    // valid bits, refill and lru strobes
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || inv_all) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= 2'b00;
            end
        end else if (fill) begin
            valid_q[buf_index][victim] <= 1'b1;
        end
    end

    assign tag_we  = {fill && victim, fill && !victim};
    assign line_we = tag_we;
    // a repeated strobe while stalled leaves the lru bit where it is
    assign use_way0 = resp_valid && !sel_return ? hit_vec[0] : fill && !victim;
    assign use_way1 = resp_valid && !sel_return ? hit_vec[1] : fill && victim;
    assign sel_way  = hit_vec[1];

    // line-aligned request, one line per miss
    assign mem_addr = {buf_addr[icache_pkg::addr_width-1:low_bit], {low_bit{1'b0}}};
    assign mem_size = icache_pkg::mem_size_word;

endmodule

`default_nettype wire

//--- icache_fetch_sel.sv
`default_nettype none

module icache_fetch_sel #(
    parameter int offset_width = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [(32<<offset_width)-1:0]  line0,
    input  logic [(32<<offset_width)-1:0]  line1,
    input  logic [(32<<offset_width)-1:0]  mem_line,
    input  logic                           sel_way,
    input  logic                           sel_return,
    input  logic [offset_width-1:0]        sel_word,
    input  logic                           stall,
    input  logic                           valid_in,
    output logic                           resp_valid,
    output logic [63:0]                    resp_instr,
    output logic                           resp_pair
);

    localparam int words = 1 << offset_width;

    logic [(32<<offset_width)-1:0] line_sel;
    logic [offset_width-1:0]       next_word;
    logic                          last_word;
    icache_pkg::word_t             lo_word;
    icache_pkg::word_t             hi_word;
    logic [63:0]                   pair_q;
    logic                          flag_q;
    logic                          hold_q;
    logic                          from_reg;

    // return path wins over the ways
    assign line_sel  = sel_return ? mem_line : (sel_way ? line1 : line0);
    assign next_word = sel_word + 1'b1;
    assign last_word = (sel_word == offset_width'(words - 1));
    assign lo_word   = line_sel[sel_word*32 +: 32];
    assign hi_word   = last_word ? icache_pkg::nop_instr : line_sel[next_word*32 +: 32];

    ////////////////////////////////////////////////////////////////////////
    // hold register
    ////////////////////////////////////////////////////////////////////////

    // refill answers come from the pair captured at the data_ok edge
    assign from_reg = hold_q || (sel_return && valid_in);

    always_ff @(posedge clk) begin
        if (!from_reg) begin
            pair_q <= {hi_word, lo_word};
            flag_q <= !last_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= stall && resp_valid;
        end
    end

    assign resp_valid = valid_in || hold_q;
    assign resp_instr = from_reg ? pair_q : {hi_word, lo_word};
    assign resp_pair  = from_reg ? flag_q : !last_word;

endmodule

`default_nettype wire

//--- icache.sv
`default_nettype none

module icache #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // pipeline side
    input  logic                              fetch_valid,
    output logic                              fetch_ready,
    input  logic [icache_pkg::addr_width-1:0] fetch_addr,
    input  logic                              fetch_inv,
    input  logic                              stall,
    output logic                              resp_valid,
    output logic [63:0]                       resp_instr,
    output logic                              resp_pair,
    // memory side
    output logic                              mem_req,
    output logic [icache_pkg::addr_width-1:0] mem_addr,
    output logic [1:0]                        mem_size,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    input  logic [(32<<offset_width)-1:0]     mem_line
);

    localparam int low_bit   = offset_width + 2;
    localparam int tag_width = icache_pkg::addr_width - index_width - low_bit;

    typedef logic [tag_width-1:0]           tag_t;
    typedef logic [(32<<offset_width)-1:0]  line_t;

    logic [icache_pkg::addr_width-1:0] buf_addr;
    logic                              buf_inv;
    logic                              buf_we;
    logic [index_width-1:0]            buf_index;
    logic [index_width-1:0]            rd_index;
    tag_t                              tag_rd [2];
    line_t                             line_rd [2];
    tag_t                              buf_tag;
    logic [1:0]                        tag_we;
    logic [1:0]                        line_we;
    logic                              victim;
    logic                              use_way0;
    logic                              use_way1;
    logic                              ctrl_valid;
    logic                              sel_way;
    logic                              sel_return;
    logic [offset_width-1:0]           sel_word;

    assign buf_index = buf_addr[low_bit+index_width-1:low_bit];
    assign buf_tag   = buf_addr[icache_pkg::addr_width-1:low_bit+index_width];
    // reread the buffered set while nothing is accepted, keeps a stalled hit stable
    assign rd_index  = buf_we ? fetch_addr[low_bit+index_width-1:low_bit] : buf_index;

    icache_req_buf u_req_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (buf_we),
        .addr     (fetch_addr),
        .inv      (fetch_inv),
        .buf_addr (buf_addr),
        .buf_inv  (buf_inv)
    );

    ////////////////////////////////////////////////////////////////////////
    // tag and line arrays, one pair per way
    ////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way_ram #(.entry_t(tag_t), .depth_width(index_width)) u_tag_ram (
            .clk   (clk),
            .raddr (rd_index),
            .rdata (tag_rd[w]),
            .waddr (buf_index),
            .wdata (buf_tag),
            .we    (tag_we[w])
        );
        icache_way_ram #(.entry_t(line_t), .depth_width(index_width)) u_line_ram (
            .clk   (clk),
            .raddr (rd_index),
            .rdata (line_rd[w]),
            .waddr (buf_index),
            .wdata (mem_line),
            .we    (line_we[w])
        );
    end

    icache_lru #(.index_width(index_width)) u_lru (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (buf_index),
        .use_way0 (use_way0),
        .use_way1 (use_way1),
        .victim   (victim)
    );

    icache_ctrl #(.index_width(index_width), .offset_width(offset_width)) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .buf_we      (buf_we),
        .buf_addr    (buf_addr),
        .buf_inv     (buf_inv),
        .tag0        (tag_rd[0]),
        .tag1        (tag_rd[1]),
        .victim      (victim),
        .use_way0    (use_way0),
        .use_way1    (use_way1),
        .tag_we      (tag_we),
        .line_we     (line_we),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .stall       (stall),
        .resp_valid  (ctrl_valid),
        .sel_way     (sel_way),
        .sel_return  (sel_return),
        .sel_word    (sel_word)
    );

    icache_fetch_sel #(.offset_width(offset_width)) u_fetch_sel (
        .clk        (clk),
        .rst_n      (rst_n),
        .line0      (line_rd[0]),
        .line1      (line_rd[1]),
        .mem_line   (mem_line),
        .sel_way    (sel_way),
        .sel_return (sel_return),
        .sel_word   (sel_word),
        .stall      (stall),
        .valid_in   (ctrl_valid),
        .resp_valid (resp_valid),
        .resp_instr (resp_instr),
        .resp_pair  (resp_pair)
    );

endmodule

`default_nettype wire

//--- tb_icache_mem.sv
`default_nettype none

module tb_icache_mem #(
    parameter int          offset_width = 2,
    parameter int unsigned seed         = 1,
    parameter logic [31:0] pattern      = 32'h0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_req,
    input  logic [31:0]                   mem_addr,
    output logic                          mem_addr_ok,
    output logic                          mem_data_ok,
    output logic [(32<<offset_width)-1:0] mem_line,
    output int                            accept_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int words = 1 << offset_width;

    logic [31:0] line_addr;
    int unsigned delay;

    // one line request at a time, random wait before each handshake
    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        line_addr   = '0;
        void'($urandom(seed));
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                mem_addr_ok = 1'b1;
                line_addr   = mem_addr;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                // word at byte address a holds (a >> 2) ^ pattern
                for (int w = 0; w < words; w++) begin
                    mem_line[w*32 +: 32] = ((line_addr >> 2) + 32'(w)) ^ pattern;
                end
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    // accepted line requests
    always @(posedge clk) begin
        if (!rst_n) begin
            accept_count <= 0;
        end else if (mem_req && mem_addr_ok) begin
            accept_count <= accept_count + 1;
        end
    end

endmodule

`default_nettype wire

//--- tb_icache_assert.sv
`default_nettype none

module tb_icache_assert (
    input logic clk,
    input logic rst_n,
    input logic mem_req,
    input logic mem_addr_ok,
    input logic resp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // request stays up until the address is taken
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_addr_ok |=> mem_req)
        else $error("mem_req dropped before mem_addr_ok");

    // no answer while a line request is still open
    resp_not_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(resp_valid && mem_req))
        else $error("resp_valid high while mem_req is raised");

endmodule

bind icache_ctrl tb_icache_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .resp_valid  (resp_valid)
);

`default_nettype wire

//--- tb_icache.sv
`default_nettype none

module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          index_width  = 4;
    localparam int          offset_width = 2;
    localparam int          line_bits    = 32 << offset_width;
    localparam logic [31:0] pattern      = 32'h5a3c_0000;
    localparam logic [31:0] nop_word     = 32'h0000_0013;
    // byte offset bits inside one line
    localparam logic [31:0] line_mask    = (32'd4 << offset_width) - 32'd1;
    // log2 of a four-byte beat
    localparam logic [1:0]  word_size    = 2'd2;
    localparam int          reset_cycles = 16;
    localparam int          num_rows     = 16;
    localparam int          max_stall    = 4;
    // lookup, request, two waits of up to 5, refill and hand-over
    localparam int          miss_cycles  = 20;
    localparam int          cycle_limit  =
        reset_cycles + num_rows * (miss_cycles + max_stall) + 100;

    logic                 clk;
    logic                 rst_n;
    logic                 fetch_valid;
    logic                 fetch_ready;
    logic [31:0]          fetch_addr;
    logic                 fetch_inv;
    logic                 stall;
    logic                 resp_valid;
    logic [63:0]          resp_instr;
    logic                 resp_pair;
    logic                 mem_req;
    logic [31:0]          mem_addr;
    logic [1:0]           mem_size;
    logic                 mem_addr_ok;
    logic                 mem_data_ok;
    logic [line_bits-1:0] mem_line;
    int                   accept_count;
    int                   cycles = 0;

    // stimulus table: address, invalidate, stall cycles, line requests so far
    logic [31:0] row_addr  [num_rows];
    logic        row_inv   [num_rows];
    int          row_stall [num_rows];
    int          row_miss  [num_rows];

    icache #(.index_width(index_width), .offset_width(offset_width)) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_addr  (fetch_addr),
        .fetch_inv   (fetch_inv),
        .stall       (stall),
        .resp_valid  (resp_valid),
        .resp_instr  (resp_instr),
        .resp_pair   (resp_pair),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    tb_icache_mem #(.offset_width(offset_width), .seed(56405), .pattern(pattern)) u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .mem_line     (mem_line),
        .accept_count (accept_count)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // expected values
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
        return (byte_addr >> 2) ^ pattern;
    endfunction

    function automatic logic last_slot(input logic [31:0] byte_addr);
        return byte_addr[offset_width+1:2] == {offset_width{1'b1}};
    endfunction

    function automatic logic [63:0] expected_pair(input logic [31:0] byte_addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = word_at(byte_addr);
        hi = last_slot(byte_addr) ? nop_word : word_at(byte_addr + 32'd4);
        return {hi, lo};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // line requests carry the aligned fetch address and a word size code
    always @(negedge clk) begin
        if (rst_n && mem_req) begin
            check_value("mem_addr", 64'(mem_addr), 64'(fetch_addr & ~line_mask));
            check_value("mem_size", 64'(mem_size), 64'(word_size));
        end
    end

    task automatic set_row(input int r, input logic [31:0] addr, input logic inv,
                           input int stall_cycles, input int misses);
        row_addr[r]  = addr;
        row_inv[r]   = inv;
        row_stall[r] = stall_cycles;
        row_miss[r]  = misses;
    endtask

    task automatic load_table();
        set_row(0,  32'h0000_0104, 1'b0, 0, 1);
        set_row(1,  32'h0000_0108, 1'b0, 0, 1);
        set_row(2,  32'h0000_010c, 1'b0, 0, 1);
        set_row(3,  32'h0000_0100, 1'b0, 4, 1);
        set_row(4,  32'h0000_0220, 1'b0, 3, 2);
        set_row(5,  32'h0000_022c, 1'b0, 0, 2);
        // three tags at set 3
        set_row(6,  32'h0000_1034, 1'b0, 0, 3);
        set_row(7,  32'h0000_2038, 1'b0, 0, 4);
        set_row(8,  32'h0000_1030, 1'b0, 0, 4);
        set_row(9,  32'h0000_303c, 1'b0, 0, 5);
        set_row(10, 32'h0000_1038, 1'b0, 0, 5);
        set_row(11, 32'h0000_2034, 1'b0, 0, 6);
        set_row(12, 32'h0000_0000, 1'b1, 0, 6);
        set_row(13, 32'h0000_0104, 1'b0, 0, 7);
        set_row(14, 32'h0000_0108, 1'b0, 2, 7);
        set_row(15, 32'h0000_0220, 1'b0, 0, 8);
    endtask

    //////////////////////////////////////////////////////////////////////
    // one fetch, entered and left on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic apply_row(input int r);
        logic [63:0] pair;
        logic        pair_flag;
        pair        = expected_pair(row_addr[r]);
        pair_flag   = !last_slot(row_addr[r]);
        fetch_addr  = row_addr[r];
        fetch_inv   = row_inv[r];
        fetch_valid = 1'b1;
        while (!fetch_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        fetch_inv   = 1'b0;
        if (row_inv[r]) begin
            check_value("resp_valid", 64'(resp_valid), 64'd0);
        end else begin
            while (!resp_valid) begin
                @(negedge clk);
            end
            check_value("resp_instr", resp_instr, pair);
            check_value("resp_pair", 64'(resp_pair), 64'(pair_flag));
            if (row_stall[r] > 0) begin
                stall = 1'b1;
                repeat (row_stall[r]) begin
                    @(negedge clk);
                    check_value("resp_valid", 64'(resp_valid), 64'd1);
                    check_value("resp_instr", resp_instr, pair);
                    check_value("resp_pair", 64'(resp_pair), 64'(pair_flag));
                end
                stall = 1'b0;
                @(negedge clk);
                // response consumed once stall dropped
                check_value("resp_valid", 64'(resp_valid), 64'd0);
            end
        end
        check_value("mem accept count", 64'(accept_count), 64'(row_miss[r]));
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        fetch_inv   = 1'b0;
        stall       = 1'b0;
        load_table();
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("fetch_ready", 64'(fetch_ready), 64'd1);
        check_value("resp_valid", 64'(resp_valid), 64'd0);
        check_value("mem_req", 64'(mem_req), 64'd0);
        for (int r = 0; r < num_rows; r++) begin
            apply_row(r);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache.f
icache_pkg.sv
icache_req_buf.sv
icache_way_ram.sv
icache_lru.sv
icache_ctrl.sv
icache_fetch_sel.sv
icache.sv
tb_icache_mem.sv
tb_icache_assert.sv
tb_icache.sv

//--- run_icache.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_icache \
    -f icache.f -o Vtb_icache \
    && ./obj_dir/Vtb_icache > sim.log 2>&1 \
    || echo "Verification failed" >> sim.log
cat sim.log
if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
